//--- files.f
src/bounce_pkg.sv
src/display_timing.sv
src/bounce_motion.sv
src/square_drawer.sv
src/framebuffer.sv
src/db_bounce_top.sv
sim/tb_db_bounce.sv

//--- Bender.yml
package:
  name: db_bounce

sources:
  - src/bounce_pkg.sv
  - src/display_timing.sv
  - src/bounce_motion.sv
  - src/square_drawer.sv
  - src/framebuffer.sv
  - src/db_bounce_top.sv
  - target: test
    files:
      - sim/tb_db_bounce.sv

//--- sim/tb_db_bounce.sv
/* directed testbench for the bouncing square display, outputs sampled on the falling edge
   frame 0 shows undefined memory and is never compared, frames 1 to 11 are */
`timescale 1ns/10ps

module tb_db_bounce import bounce_pkg::*; ();

    localparam int N_FRAMES       = 12;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT_CYCLES = N_FRAMES * FRAME_CYCLES + 1000;

    logic clk_100m = 1'b0;
    logic rst_n;
    rgb_t rgb;
    logic disp_de, disp_hsync, disp_vsync;

    int   checks = 0;
    int   check_errors = 0;
    int   other_errors = 0;
    int   cycle_cnt = 0;
    int   mx [N_FRAMES];  // model corner per frame pulse
    int   my [N_FRAMES];
    int   last_x, last_y;  // corner of the previously checked frame

    // filled by the capture block below
    rgb_t frame_img [FB_DEPTH];
    int   shown_frame = 0;
    int   img_frame = 0;   // last fully captured frame
    int   pix_idx = 0;
    logic capturing = 1'b0;
    logic vsync_q = 1'b0;

    db_bounce_top dut (
        .clk_100m   (clk_100m),
        .rst_n      (rst_n),
        .rgb        (rgb),
        .disp_de    (disp_de),
        .disp_hsync (disp_hsync),
        .disp_vsync (disp_vsync)
    );

    always #5 clk_100m = ~clk_100m;

    always @(posedge clk_100m) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // frame capture, a vsync falling edge starts the next displayed frame
    always @(negedge clk_100m) begin
        vsync_q <= disp_vsync;
        if (!rst_n) begin
            capturing <= 1'b0;
        end else if (vsync_q && !disp_vsync) begin
            shown_frame <= shown_frame + 1;
            pix_idx     <= 0;
            capturing   <= 1'b1;
        end else if (capturing && disp_de) begin
            frame_img[pix_idx] <= rgb;
            pix_idx            <= pix_idx + 1;
            if (pix_idx == FB_DEPTH - 1) begin
                capturing <= 1'b0;
                img_frame <= shown_frame;
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // edge bounce on one axis
    function automatic void move_axis(inout int pos, inout int back, input int extent);
        if (pos >= extent - SQ_SIZE - SQ_SPEED)
            back = 1;
        else if (pos < SQ_SPEED)
            back = 0;
        pos = back ? pos - SQ_SPEED : pos + SQ_SPEED;
    endfunction

    task automatic build_model();
        int x, y, left, up;
        x = 0;
        y = 0;
        left = 0;
        up = 0;
        for (int j = 0; j < N_FRAMES; j++) begin
            mx[j] = x;  // corner before the update at pulse j
            my[j] = y;
            move_axis(x, left, FB_WIDTH);
            move_axis(y, up, FB_HEIGHT);
        end
    endtask

    task automatic wait_image(input int n);
        while (img_frame < n) @(negedge clk_100m);
        if (img_frame != n) begin
            other_errors++;
            $display("displayed frame %0d was replaced before it could be compared", n);
        end
    endtask

    // frame n shows the corner latched at pulse n-1
    task automatic compare_frame(input int n, output int cx, output int cy);
        int   row, col, sq_cnt;
        logic in_square;
        rgb_t exp;
        wait_image(n);
        cx = -1;
        cy = -1;
        sq_cnt = 0;
        for (int i = 0; i < FB_DEPTH; i++) begin
            row = i / FB_WIDTH;
            col = i % FB_WIDTH;
            in_square = col >= mx[n-1] && col < mx[n-1] + SQ_SIZE &&
                        row >= my[n-1] && row < my[n-1] + SQ_SIZE;
            exp = in_square ? PALETTE[SQ_IDX] : PALETTE[BG_IDX];
            check_value($sformatf("rgb frame %0d x %0d y %0d", n, col, row), frame_img[i], exp);
            if (frame_img[i] === PALETTE[SQ_IDX]) begin
                sq_cnt++;
                if (cx < 0) begin
                    cx = col;  // first square pixel in raster order
                    cy = row;
                end
            end
        end
        check_value($sformatf("square pixels frame %0d", n), sq_cnt, SQ_SIZE * SQ_SIZE);
        check_value($sformatf("corner x frame %0d", n), cx, mx[n-1]);
        check_value($sformatf("corner y frame %0d", n), cy, my[n-1]);
    endtask

    task automatic reset_outputs();
        repeat (3) begin
            @(negedge clk_100m);
            check_value("disp_de", disp_de, 0);
            check_value("disp_hsync", disp_hsync, 0);
            check_value("disp_vsync", disp_vsync, 0);
            check_value("rgb", rgb, 0);
        end
        rst_n = 1'b1;
        @(negedge clk_100m);  // pipeline still empty
        check_value("disp_de", disp_de, 0);
        check_value("disp_hsync", disp_hsync, 0);
        check_value("disp_vsync", disp_vsync, 0);
        check_value("rgb", rgb, 0);
    endtask

    task automatic sync_counts();
        int n_de, n_hs, n_vs;
        int n_blank;  // blanking cycles with a colour on rgb
        n_de = 0;
        n_hs = 0;
        n_vs = 0;
        n_blank = 0;
        repeat (FRAME_CYCLES) begin
            @(negedge clk_100m);
            if (disp_de === 1'b1) n_de++;
            if (disp_hsync === 1'b1) n_hs++;
            if (disp_vsync === 1'b1) n_vs++;
            if (disp_de === 1'b0 && rgb !== 12'h000) n_blank++;
        end
        check_value("disp_de count", n_de, 64 * 36);
        check_value("disp_hsync count", n_hs, 8 * 45);
        check_value("disp_vsync count", n_vs, 2 * 80);
        check_value("rgb nonzero while disp_de low", n_blank, 0);
    endtask

    task automatic first_image();
        compare_frame(1, last_x, last_y);
    endtask

    task automatic motion_frames();
        int cx, cy;
        for (int n = 2; n <= 9; n++) begin
            compare_frame(n, cx, cy);
            check_value($sformatf("x step frame %0d", n), cx - last_x, SQ_SPEED);
            check_value($sformatf("y step frame %0d", n), cy - last_y, SQ_SPEED);
            last_x = cx;
            last_y = cy;
        end
    endtask

    // y hits its limit at pulse 9, the reversal shows in frame 11
    task automatic bounce_frames();
        int cx, cy;
        compare_frame(10, cx, cy);
        check_value("y step frame 10", cy - last_y, SQ_SPEED);
        last_x = cx;
        last_y = cy;
        compare_frame(11, cx, cy);
        check_value("x step frame 11", cx - last_x, SQ_SPEED);
        check_value("y step frame 11", cy - last_y, -SQ_SPEED);
    endtask

    initial begin
        rst_n = 1'b0;
        build_model();
        reset_outputs();
        sync_counts();
        first_image();
        motion_frames();
        bounce_frames();
        $display("checks %0d, check failures %0d, other errors %0d",
                 checks, check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- src/db_bounce_top.sv
/* double-buffered bouncing square on a 64x36 simulation raster
   one clock, one pixel per cycle, 12-bit RGB with sync and de */
`timescale 1ns/10ps

module db_bounce_top import bounce_pkg::*; (
    input  logic clk_100m,
    input  logic rst_n,
    output rgb_t rgb,
    output logic disp_de,
    output logic disp_hsync,
    output logic disp_vsync
);

    coord_t sx, sy;
    logic   hsync, vsync, de, frame;
    coord_t sq_x, sq_y;     // square corner
    logic   we;
    coord_t wx, wy;
    cidx_t  wcidx;
    logic   draw_done;

    display_timing u_timing (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .sx       (sx),
        .sy       (sy),
        .hsync    (hsync),
        .vsync    (vsync),
        .de       (de),
        .frame    (frame)
    );

    bounce_motion u_motion (
        .clk_100m (clk_100m),
        .rst_n    (rst_n),
        .frame    (frame),
        .sq_x     (sq_x),
        .sq_y     (sq_y)
    );

    square_drawer u_drawer (
        .clk_100m  (clk_100m),
        .rst_n     (rst_n),
        .frame     (frame),
        .sq_x      (sq_x),
        .sq_y      (sq_y),
        .we        (we),
        .wx        (wx),
        .wy        (wy),
        .wcidx     (wcidx),
        .draw_done (draw_done)
    );

    framebuffer u_fb (
        .clk_100m   (clk_100m),
        .rst_n      (rst_n),
        .frame      (frame),
        .draw_done  (draw_done),
        .we         (we),
        .wx         (wx),
        .wy         (wy),
        .wcidx      (wcidx),
        .sx         (sx),
        .sy         (sy),
        .de         (de),
        .hsync      (hsync),
        .vsync      (vsync),
        .rgb        (rgb),
        .disp_de    (disp_de),
        .disp_hsync (disp_hsync),
        .disp_vsync (disp_vsync)
    );

endmodule

//--- src/framebuffer.sv
/* two banks of colour indices, writes go to the back bank and never stall
   banks swap at a frame pulse while draw_done is high, front bank is undefined
   until the first swap; sx/sy/de/syncs reach the outputs 2 cycles later */
`timescale 1ns/10ps

module framebuffer import bounce_pkg::*; (
    input  logic   clk_100m,
    input  logic   rst_n,
    input  logic   frame,
    input  logic   draw_done,
    input  logic   we,
    input  coord_t wx,
    input  coord_t wy,
    input  cidx_t  wcidx,
    input  coord_t sx,
    input  coord_t sy,
    input  logic   de,
    input  logic   hsync,
    input  logic   vsync,
    output rgb_t   rgb,
    output logic   disp_de,
    output logic   disp_hsync,
    output logic   disp_vsync
);

    cidx_t mem [2][FB_DEPTH];
    logic  front;    // bank being displayed
    logic  rd_bank;
    logic  wr_bank;
    addr_t waddr;
    addr_t raddr;
    cidx_t rdata;
    logic  de_d, hsync_d, vsync_d;  // aligned with rdata

    // new bank is already read on the first pixel of the swap frame
    assign rd_bank = front ^ (frame & draw_done);
    assign wr_bank = ~rd_bank;
    assign waddr   = addr_t'(wy * FB_WIDTH + wx);
    assign raddr   = addr_t'(sy * FB_WIDTH + sx);

    always_ff @(posedge clk_100m) begin
        if (!rst_n) front <= 1'b0;
        else        front <= rd_bank;
    end

    always_ff @(posedge clk_100m) begin
        if (we) mem[wr_bank][waddr] <= wcidx;
    end

    always_ff @(posedge clk_100m) begin
        if (de) rdata <= mem[rd_bank][raddr];
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            de_d       <= 1'b0;
            hsync_d    <= 1'b0;
            vsync_d    <= 1'b0;
            disp_de    <= 1'b0;
            disp_hsync <= 1'b0;
            disp_vsync <= 1'b0;
            rgb        <= '0;
        end else begin
            de_d       <= de;
            hsync_d    <= hsync;
            vsync_d    <= vsync;
            disp_de    <= de_d;
            disp_hsync <= hsync_d;
            disp_vsync <= vsync_d;
            rgb        <= de_d ? PALETTE[rdata] : rgb_t'(0);  // blank outside active area
        end
    end

    // drawer must be idle when the banks swap
    swap_without_write: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        (frame && draw_done) |-> !we
    );

endmodule

//--- src/square_drawer.sv
/* redraws the back buffer once per frame: full clear, then the square
   a frame pulse is only accepted in IDLE or DONE, drawing takes about 2560 cycles */
`timescale 1ns/10ps

module square_drawer import bounce_pkg::*; (
    input  logic   clk_100m,
    input  logic   rst_n,
    input  logic   frame,
    input  coord_t sq_x,
    input  coord_t sq_y,
    output logic   we,
    output coord_t wx,
    output coord_t wy,
    output cidx_t  wcidx,
    output logic   draw_done
);

    typedef enum logic [1:0] {IDLE, CLEAR, FILL, DONE} state_t;

    state_t state;
    coord_t x0, y0;  // latched square corner
    logic   start;
    logic   x_last;
    logic   y_last;

    assign start = frame && (state == IDLE || state == DONE);

    // cursor limits depend on the phase
    always_comb begin
        if (state == CLEAR) begin
            x_last = (wx == FB_WIDTH - 1);
            y_last = (wy == FB_HEIGHT - 1);
        end else begin
            x_last = (wx == x0 + SQ_SIZE - 1);
            y_last = (wy == y0 + SQ_SIZE - 1);
        end
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            state     <= IDLE;
            we        <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state     <= CLEAR;
                        we        <= 1'b1;
                        draw_done <= 1'b0;
                    end
                end
                CLEAR: if (x_last && y_last) state <= FILL;
                FILL: begin
                    if (x_last && y_last) begin
                        state     <= DONE;
                        we        <= 1'b0;
                        draw_done <= 1'b1;  // held until next frame pulse
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // write cursor and colour
    always_ff @(posedge clk_100m) begin
        if (start) begin
            x0    <= sq_x;  // position before this frame's motion update
            y0    <= sq_y;
            wx    <= '0;
            wy    <= '0;
            wcidx <= BG_IDX;
        end else if (state == CLEAR && x_last && y_last) begin
            wx    <= x0;  // clear finished, jump to square
            wy    <= y0;
            wcidx <= SQ_IDX;
        end else if (state == CLEAR || state == FILL) begin
            if (x_last) begin
                wx <= (state == CLEAR) ? coord_t'(0) : x0;
                wy <= coord_t'(wy + 1);
            end else begin
                wx <= coord_t'(wx + 1);
            end
        end
    end

    we_only_while_drawing: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        we |-> (state == CLEAR || state == FILL) && !draw_done
    );

endmodule

//--- src/bounce_motion.sv
/* square corner moves SQ_SPEED per frame on both axes, reversing at the edges
   reset position is the top-left corner, heading right and down */
`timescale 1ns/10ps

module bounce_motion import bounce_pkg::*; (
    input  logic   clk_100m,
    input  logic   rst_n,
    input  logic   frame,
    output coord_t sq_x,
    output coord_t sq_y
);

    logic   dir_x;  // 1 moves left
    logic   dir_y;  // 1 moves up
    coord_t nx, ny;
    logic   ndx, ndy;

    // edge-bounce rule for one axis, lim is the buffer extent
    function automatic void step_axis(input coord_t pos, input logic dir, input int lim,
                                      output coord_t pos_n, output logic dir_n);
        if (pos >= lim - SQ_SIZE - SQ_SPEED) begin
            dir_n = 1'b1;
            pos_n = coord_t'(pos - SQ_SPEED);
        end else if (pos < SQ_SPEED) begin
            dir_n = 1'b0;
            pos_n = coord_t'(pos + SQ_SPEED);
        end else begin
            dir_n = dir;
            pos_n = dir ? coord_t'(pos - SQ_SPEED) : coord_t'(pos + SQ_SPEED);
        end
    endfunction

    always_comb begin
        step_axis(sq_x, dir_x, FB_WIDTH, nx, ndx);
        step_axis(sq_y, dir_y, FB_HEIGHT, ny, ndy);
    end

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            sq_x  <= '0;
            sq_y  <= '0;
            dir_x <= 1'b0;
            dir_y <= 1'b0;
        end else if (frame) begin
            sq_x  <= nx;
            sq_y  <= ny;
            dir_x <= ndx;
            dir_y <= ndy;
        end
    end

    square_inside_fb: assert property (@(posedge clk_100m) disable iff (!rst_n)
        sq_x >= 0 && sq_x <= FB_WIDTH - SQ_SIZE && sq_y >= 0 && sq_y <= FB_HEIGHT - SQ_SIZE);

endmodule

//--- src/display_timing.sv
/* free-running raster counters, no blanking porch options
   frame pulses at sx = sy = 0, so also in the first cycle out of reset */
`timescale 1ns/10ps

module display_timing import bounce_pkg::*; (
    input  logic   clk_100m,
    input  logic   rst_n,
    output coord_t sx,
    output coord_t sy,
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output logic   frame
);

    logic h_last;
    logic v_last;

    assign h_last = (sx == H_TOTAL - 1);  // end of line
    assign v_last = (sy == V_TOTAL - 1);  // last line of frame

    always_ff @(posedge clk_100m) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (h_last) begin
            sx <= '0;
            sy <= v_last ? coord_t'(0) : coord_t'(sy + 1);
        end else begin
            sx <= coord_t'(sx + 1);
        end
    end

    // decoded from the counters, valid in the same cycle
    always_comb begin
        hsync = (sx >= H_SYNC_START) && (sx <= H_SYNC_END);
        vsync = (sy >= V_SYNC_START) && (sy <= V_SYNC_END);
        de    = (sx < H_ACTIVE) && (sy < V_ACTIVE);
        frame = (sx == 0) && (sy == 0);
    end

    // one pulse per frame, never stretched
    frame_single_cycle: assert property (
        @(posedge clk_100m) disable iff (!rst_n)
        frame |=> !frame
    );

endmodule

//--- src/bounce_pkg.sv
/* raster, framebuffer and square geometry for the simulation-sized display
   framebuffer covers the active area exactly, one colour index per pixel */
package bounce_pkg;

    // shared vector types
    typedef logic signed [7:0] coord_t;  // screen or framebuffer coordinate
    typedef logic [3:0]        cidx_t;   // palette index
    typedef logic [11:0]       rgb_t;    // 4 bits per channel, red high
    typedef logic [11:0]       addr_t;   // framebuffer word address within a bank

    // raster geometry, one pixel per clock
    localparam int H_ACTIVE     = 64;
    localparam int H_SYNC_START = 68;
    localparam int H_SYNC_END   = 75;  // inclusive
    localparam int H_TOTAL      = 80;

    localparam int V_ACTIVE     = 36;
    localparam int V_SYNC_START = 38;
    localparam int V_SYNC_END   = 39;  // inclusive
    localparam int V_TOTAL      = 45;

    // framebuffer
    localparam int FB_WIDTH  = 64;
    localparam int FB_HEIGHT = 36;
    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT;  // words per bank

    // bouncing square
    localparam int SQ_SIZE  = 16;  // edge length in pixels
    localparam int SQ_SPEED = 2;   // pixels per frame on each axis

    localparam cidx_t BG_IDX = 4'd1;
    localparam cidx_t SQ_IDX = 4'd11;

    // fixed 16 colour palette
    localparam rgb_t PALETTE [16] = '{
        12'h000,  // 0 black
        12'h112,  // 1 background, dark blue
        12'hF00,
        12'hF80,
        12'hFF0,
        12'h8F0,
        12'h0F0,
        12'h0F8,
        12'h0FF,
        12'h08F,
        12'h00F,
        12'h2C4,  // 11 square, green
        12'h80F,
        12'hF0F,
        12'h888,
        12'hFFF   // 15 white
    };

endpackage
